//--- Makefile
TOOL  = verilator
FLAGS = --binary --timing --assert
TOP   = tbSpecFreeList
FILES = src.f
BIN   = obj_dir/V$(TOP)
PASS  = Test OK

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILES)

run: build
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS)"

lint:
	$(TOOL) --lint-only --timing -Wall --top-module $(TOP) -f $(FILES)

clean:
	rm -rf obj_dir

//--- logic/commitPacker.sv
`timescale 1ns/1ps

module commitPacker #(
  parameter int Depth = freeListPkg::DefaultDepth,
  parameter int CommitWidth = freeListPkg::DefaultCommitWidth
) (
  input  logic                                      clk,
  input  logic                                      reset,
  input  logic                                      freedValid_i [CommitWidth],
  input  freeListPkg::phyReg_t                      freedPhyReg_i [CommitWidth],
  output logic                                      wrEn_o [CommitWidth],
  output logic [((Depth > 1) ? $clog2(Depth) : 1)-1:0] wrAddr_o [CommitWidth],
  output freeListPkg::phyReg_t                      wrData_o [CommitWidth],
  output logic [$clog2(CommitWidth + 1)-1:0]        pushCount_o,
  output logic [((Depth > 1) ? $clog2(Depth) : 1)-1:0] tail_o
);

  localparam int PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int PushW = $clog2(CommitWidth + 1);

  logic [PtrW-1:0] tail;
  logic [PtrW-1:0] tailNext;

  // slot addresses run from the tail and wrap at Depth
  always_comb
  begin
    int sum;
    for (int s = 0; s < CommitWidth; s++)
    begin
      sum = int'(tail) + s;
      if (sum >= Depth)
        sum = sum - Depth;
      wrAddr_o[s] = PtrW'(sum);
    end
  end

  // valid lanes land on consecutive slots in lane order
  always_comb
  begin
    int slot;
    slot = 0;
    for (int s = 0; s < CommitWidth; s++)
    begin
      wrEn_o[s]   = 1'b0;
      wrData_o[s] = '0;
    end
    for (int l = 0; l < CommitWidth; l++)
    begin
      if (freedValid_i[l])
      begin
        wrEn_o[slot]   = 1'b1;
        wrData_o[slot] = freedPhyReg_i[l];
        slot           = slot + 1;
      end
    end
    pushCount_o = PushW'(slot);
  end

  always_comb
  begin
    int sum;
    sum = int'(tail) + int'(pushCount_o);
    if (sum >= Depth)
      sum = sum - Depth;
    tailNext = PtrW'(sum);
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      tail <= '0;
    else
      tail <= tailNext;
  end

  assign tail_o = tail;

endmodule

//--- logic/freeListInit.sv
`timescale 1ns/1ps

module freeListInit #(
  parameter int Depth = freeListPkg::DefaultDepth
) (
  input  logic                                      clk,
  input  logic                                      resetRams_i,
  output logic                                      initWe_o,
  output logic [((Depth > 1) ? $clog2(Depth) : 1)-1:0] initAddr_o,
  output freeListPkg::phyReg_t                      initData_o,
  output logic                                      ready_o
);

  localparam int PtrW = (Depth > 1) ? $clog2(Depth) : 1;

  freeListPkg::initState_e state;
  freeListPkg::initState_e stateNext;
  logic [PtrW-1:0]         addr;
  logic [PtrW-1:0]         addrNext;
  freeListPkg::phyReg_t    tag;
  freeListPkg::phyReg_t    tagNext;

  always_ff @(posedge clk or posedge resetRams_i)
  begin
    if (resetRams_i)
    begin
      state <= freeListPkg::initStart;
      addr  <= '0;
      tag   <= freeListPkg::phyReg_t'(freeListPkg::NumArchRegs);
    end
    else
    begin
      state <= stateNext;
      addr  <= addrNext;
      tag   <= tagNext;
    end
  end

  always_comb
  begin
    stateNext = state;
    addrNext  = addr;
    tagNext   = tag;
    case (state)
      freeListPkg::initStart:
      begin
        stateNext = freeListPkg::initRun;
        addrNext  = '0;
        tagNext   = freeListPkg::phyReg_t'(freeListPkg::NumArchRegs);
      end
      freeListPkg::initRun:
      begin
        addrNext = addr + 1'b1;
        tagNext  = tag + 1'b1;
        // last entry written this cycle
        if (addr == PtrW'(Depth - 1))
          stateNext = freeListPkg::initDone;
      end
      default:
      begin
        stateNext = state;
      end
    endcase
  end

  assign initWe_o   = (state == freeListPkg::initRun);
  assign initAddr_o = addr;
  assign initData_o = tag;
  assign ready_o    = (state == freeListPkg::initDone);

  // every entry receives NumArchRegs plus its own address
  aTagMatchesAddr: assert property (@(posedge clk) disable iff (resetRams_i)
    initWe_o |-> (int'(initData_o) == freeListPkg::NumArchRegs + int'(initAddr_o)));

endmodule

//--- logic/freeListPkg.sv
package freeListPkg;

  // architectural registers own the first NumArchRegs tags
  parameter int NumArchRegs = 32;
  parameter int NumPhysRegs = 64;

  // free list holds every tag not mapped by the architectural state
  parameter int DefaultDepth = NumPhysRegs - NumArchRegs;

  parameter int DefaultDispatchWidth = 2;
  parameter int DefaultCommitWidth = 2;

  typedef logic [$clog2(NumPhysRegs)-1:0] phyReg_t;

  // initialiser walks the RAM once after resetRams_i
  typedef enum logic [1:0]
  {
    initStart,
    initRun,
    initDone
  } initState_e;

endpackage

//--- logic/freeListRam.sv
`timescale 1ns/1ps

module freeListRam #(
  parameter int Depth = freeListPkg::DefaultDepth,
  parameter int DispatchWidth = freeListPkg::DefaultDispatchWidth,
  parameter int CommitWidth = freeListPkg::DefaultCommitWidth
) (
  input  logic                                      clk,
  input  logic [((Depth > 1) ? $clog2(Depth) : 1)-1:0] rdAddr_i [DispatchWidth],
  output freeListPkg::phyReg_t                      rdData_o [DispatchWidth],
  input  logic                                      wrEn_i [CommitWidth],
  input  logic [((Depth > 1) ? $clog2(Depth) : 1)-1:0] wrAddr_i [CommitWidth],
  input  freeListPkg::phyReg_t                      wrData_i [CommitWidth],
  input  logic                                      initWe_i,
  input  logic [((Depth > 1) ? $clog2(Depth) : 1)-1:0] initAddr_i,
  input  freeListPkg::phyReg_t                      initData_i
);

  localparam int PtrW = (Depth > 1) ? $clog2(Depth) : 1;

  freeListPkg::phyReg_t mem [Depth];

  logic                 we0;
  logic [PtrW-1:0]      addr0;
  freeListPkg::phyReg_t data0;
  logic                 wrEnAny;

  // initialiser wins port 0
  always_comb
  begin
    we0   = initWe_i | wrEn_i[0];
    addr0 = initWe_i ? initAddr_i : wrAddr_i[0];
    data0 = initWe_i ? initData_i : wrData_i[0];
  end

  always_ff @(posedge clk)
  begin
    if (we0)
      mem[addr0] <= data0;
    for (int w = 1; w < CommitWidth; w++)
    begin
      if (wrEn_i[w])
        mem[wrAddr_i[w]] <= wrData_i[w];
    end
  end

  for (genvar r = 0; r < DispatchWidth; r++)
  begin : gRead
    assign rdData_o[r] = mem[rdAddr_i[r]];
  end

  always_comb
  begin
    wrEnAny = 1'b0;
    for (int w = 0; w < CommitWidth; w++)
      wrEnAny = wrEnAny | wrEn_i[w];
  end

  // commit must stay quiet until the initialiser has filled the list
  aNoCommitDuringInit: assert property (@(posedge clk) initWe_i |-> !wrEnAny);

endmodule

//--- logic/headTracker.sv
`timescale 1ns/1ps

module headTracker #(
  parameter int Depth = freeListPkg::DefaultDepth,
  parameter int DispatchWidth = freeListPkg::DefaultDispatchWidth,
  parameter int CommitWidth = freeListPkg::DefaultCommitWidth
) (
  input  logic                                      clk,
  input  logic                                      reset,
  input  logic                                      stall_i,
  input  logic                                      recoverFlag_i,
  input  logic                                      reqPhyReg_i [DispatchWidth],
  input  logic [$clog2(CommitWidth + 1)-1:0]        pushCount_i,
  input  logic [((Depth > 1) ? $clog2(Depth) : 1)-1:0] tail_i,
  input  freeListPkg::phyReg_t                      rdData_i [DispatchWidth],
  output logic [((Depth > 1) ? $clog2(Depth) : 1)-1:0] rdAddr_o [DispatchWidth],
  output freeListPkg::phyReg_t                      freePhyReg_o [DispatchWidth],
  output logic                                      freeListEmpty_o
);

  localparam int PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int CntW = $clog2(Depth + 1);

  logic [PtrW-1:0] head;
  logic [PtrW-1:0] headNext;
  logic [CntW-1:0] count;
  logic [CntW-1:0] countNext;
  int              popCount;

  assign freeListEmpty_o = (int'(count) < DispatchWidth);

  // lane r reads head + r
  always_comb
  begin
    int sum;
    for (int r = 0; r < DispatchWidth; r++)
    begin
      sum = int'(head) + r;
      if (sum >= Depth)
        sum = sum - Depth;
      rdAddr_o[r] = PtrW'(sum);
    end
  end

  for (genvar r = 0; r < DispatchWidth; r++)
  begin : gOut
    assign freePhyReg_o[r] = freeListEmpty_o ? '0 : rdData_i[r];
  end

  // requests only pop when the list can hand out a full group
  always_comb
  begin
    popCount = 0;
    if (!stall_i && !freeListEmpty_o)
    begin
      for (int r = 0; r < DispatchWidth; r++)
        popCount = popCount + int'(reqPhyReg_i[r]);
    end
  end

  always_comb
  begin
    int sum;
    sum = int'(head) + popCount;
    if (sum >= Depth)
      sum = sum - Depth;
    headNext  = PtrW'(sum);
    countNext = CntW'(int'(count) + int'(pushCount_i) - popCount);
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      head  <= '0;
      count <= CntW'(Depth);
    end
    else if (recoverFlag_i)
    begin
      // squash everything speculative, list is full again
      head  <= tail_i;
      count <= CntW'(Depth);
    end
    else
    begin
      head  <= headNext;
      count <= countNext;
    end
  end

  // commit can never return more tags than rename took out
  aCountBound: assert property (@(posedge clk) disable iff (reset) int'(count) <= Depth);

endmodule

//--- logic/specFreeList.sv
`timescale 1ns/1ps

module specFreeList #(
  parameter int Depth = freeListPkg::DefaultDepth,
  parameter int DispatchWidth = freeListPkg::DefaultDispatchWidth,
  parameter int CommitWidth = freeListPkg::DefaultCommitWidth
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 resetRams_i,
  input  logic                 stall_i,
  input  logic                 recoverFlag_i,
  input  logic                 reqPhyReg_i [DispatchWidth],
  input  logic                 freedValid_i [CommitWidth],
  input  freeListPkg::phyReg_t freedPhyReg_i [CommitWidth],
  output freeListPkg::phyReg_t freePhyReg_o [DispatchWidth],
  output logic                 freeListEmpty_o,
  output logic                 flRamReady_o
);

  localparam int PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int PushW = $clog2(CommitWidth + 1);

  logic                 initWe;
  logic [PtrW-1:0]      initAddr;
  freeListPkg::phyReg_t initData;

  logic                 wrEn [CommitWidth];
  logic [PtrW-1:0]      wrAddr [CommitWidth];
  freeListPkg::phyReg_t wrData [CommitWidth];

  logic [PtrW-1:0]      rdAddr [DispatchWidth];
  freeListPkg::phyReg_t rdData [DispatchWidth];

  logic [PushW-1:0]     pushCount;
  logic [PtrW-1:0]      tail;

  freeListInit #(.Depth(Depth)) i_freeListInit (
    .clk        (clk),
    .resetRams_i(resetRams_i),
    .initWe_o   (initWe),
    .initAddr_o (initAddr),
    .initData_o (initData),
    .ready_o    (flRamReady_o)
  );

  // initialiser and commit lane 0 share write port 0
  freeListRam #(
    .Depth        (Depth),
    .DispatchWidth(DispatchWidth),
    .CommitWidth  (CommitWidth)
  ) i_freeListRam (
    .clk       (clk),
    .rdAddr_i  (rdAddr),
    .rdData_o  (rdData),
    .wrEn_i    (wrEn),
    .wrAddr_i  (wrAddr),
    .wrData_i  (wrData),
    .initWe_i  (initWe),
    .initAddr_i(initAddr),
    .initData_i(initData)
  );

  commitPacker #(
    .Depth      (Depth),
    .CommitWidth(CommitWidth)
  ) i_commitPacker (
    .clk          (clk),
    .reset        (reset),
    .freedValid_i (freedValid_i),
    .freedPhyReg_i(freedPhyReg_i),
    .wrEn_o       (wrEn),
    .wrAddr_o     (wrAddr),
    .wrData_o     (wrData),
    .pushCount_o  (pushCount),
    .tail_o       (tail)
  );

  headTracker #(
    .Depth        (Depth),
    .DispatchWidth(DispatchWidth),
    .CommitWidth  (CommitWidth)
  ) i_headTracker (
    .clk            (clk),
    .reset          (reset),
    .stall_i        (stall_i),
    .recoverFlag_i  (recoverFlag_i),
    .reqPhyReg_i    (reqPhyReg_i),
    .pushCount_i    (pushCount),
    .tail_i         (tail),
    .rdData_i       (rdData),
    .rdAddr_o       (rdAddr),
    .freePhyReg_o   (freePhyReg_o),
    .freeListEmpty_o(freeListEmpty_o)
  );

endmodule

//--- sim/freeListCases.txt
# req0 req1 freedValid0 freedValid1 freedTag0 freedTag1 stall recover
#   then expected freePhyReg0 freePhyReg1 empty, all decimal, one line per cycle
0 0 0 0 0  0  0 0 32 33 0
1 1 0 0 0  0  0 0 32 33 0
1 1 0 0 0  0  0 0 34 35 0
1 0 0 0 0  0  0 0 36 37 0
1 1 0 1 0  33 0 0 37 38 0
0 0 1 1 32 35 0 0 39 40 0
1 1 1 0 34 0  1 0 39 40 0
1 1 0 0 0  0  1 0 39 40 0
1 1 0 0 0  0  0 0 39 40 0
1 1 0 0 0  0  0 0 41 42 0
1 1 0 0 0  0  0 0 43 44 0
1 1 0 0 0  0  0 0 45 46 0
1 1 0 0 0  0  0 0 47 48 0
1 1 0 0 0  0  0 0 49 50 0
1 1 0 0 0  0  0 0 51 52 0
1 1 0 0 0  0  0 0 53 54 0
1 1 0 0 0  0  0 0 55 56 0
1 1 0 0 0  0  0 0 57 58 0
1 1 0 0 0  0  0 0 59 60 0
1 1 0 0 0  0  0 0 61 62 0
1 1 0 0 0  0  0 0 63 33 0
1 1 0 0 0  0  0 0 32 35 0
1 1 0 0 0  0  0 0 0  0  1
1 1 0 1 0  36 0 0 0  0  1
0 0 0 0 0  0  0 0 34 36 0
1 1 0 0 0  0  0 0 34 36 0
1 1 0 0 0  0  0 0 0  0  1
1 1 1 0 37 0  0 1 0  0  1
0 0 0 0 0  0  0 0 37 38 0
1 1 0 0 0  0  0 0 37 38 0
0 0 0 0 0  0  0 0 39 40 0

//--- sim/tbSpecFreeList.sv
`timescale 1ns/1ps

module tbSpecFreeList;

  localparam int Depth = freeListPkg::DefaultDepth;
  localparam int DispatchWidth = freeListPkg::DefaultDispatchWidth;
  localparam int CommitWidth = freeListPkg::DefaultCommitWidth;
  localparam int NumCols = 11;
  localparam int ClkPeriod = 4;

  logic                 clk;
  logic                 reset;
  logic                 resetRams;
  logic                 stall;
  logic                 recoverFlag;
  logic                 reqPhyReg [DispatchWidth];
  logic                 freedValid [CommitWidth];
  freeListPkg::phyReg_t freedPhyReg [CommitWidth];
  freeListPkg::phyReg_t freePhyReg [DispatchWidth];
  logic                 freeListEmpty;
  logic                 flRamReady;

  // case lines flattened, NumCols fields per line
  int   fields[$];
  int   numCases;
  logic casesLoaded;

  specFreeList #(
    .Depth        (Depth),
    .DispatchWidth(DispatchWidth),
    .CommitWidth  (CommitWidth)
  ) i_specFreeList (
    .clk            (clk),
    .reset          (reset),
    .resetRams_i    (resetRams),
    .stall_i        (stall),
    .recoverFlag_i  (recoverFlag),
    .reqPhyReg_i    (reqPhyReg),
    .freedValid_i   (freedValid),
    .freedPhyReg_i  (freedPhyReg),
    .freePhyReg_o   (freePhyReg),
    .freeListEmpty_o(freeListEmpty),
    .flRamReady_o   (flRamReady)
  );

  initial
  begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  task automatic abortRun(input string why);
    $display("%s", why);
    $display("Test FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic checkPhyReg(input string name, input freeListPkg::phyReg_t act,
                             input freeListPkg::phyReg_t exp);
    if (act !== exp)
      abortRun($sformatf("Fail at %0t: %s is %0d, expected %0d", $time, name, act, exp));
  endtask

  task automatic checkFlag(input string name, input logic act, input logic exp);
    if (act !== exp)
      abortRun($sformatf("Fail at %0t: %s is %b, expected %b", $time, name, act, exp));
  endtask

  task automatic loadCases();
    int    fd;
    int    code;
    int    got;
    string line;
    int    v [NumCols];
    fd = $fopen("sim/freeListCases.txt", "r");
    if (fd == 0)
      abortRun("could not open the cases file sim/freeListCases.txt");
    else
    begin
      while (!$feof(fd))
      begin
        line = "";
        code = $fgets(line, fd);
        // skip blank and comment lines
        if (code > 0 && line.len() > 1 && line.getc(0) != "#")
        begin
          got = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d", v[0], v[1], v[2],
                        v[3], v[4], v[5], v[6], v[7], v[8], v[9], v[10]);
          if (got != NumCols)
            abortRun($sformatf("malformed line in the cases file: %s", line));
          else
            for (int k = 0; k < NumCols; k++)
              fields.push_back(v[k]);
        end
      end
      $fclose(fd);
      numCases = fields.size() / NumCols;
    end
  endtask

  task automatic driveIdle();
    stall       = 1'b0;
    recoverFlag = 1'b0;
    for (int r = 0; r < DispatchWidth; r++)
      reqPhyReg[r] = 1'b0;
    for (int c = 0; c < CommitWidth; c++)
    begin
      freedValid[c]  = 1'b0;
      freedPhyReg[c] = '0;
    end
  endtask

  // columns 0..7 are stimulus
  task automatic driveCase(input int n);
    int base;
    base           = n * NumCols;
    reqPhyReg[0]   = (fields[base] != 0);
    reqPhyReg[1]   = (fields[base + 1] != 0);
    freedValid[0]  = (fields[base + 2] != 0);
    freedValid[1]  = (fields[base + 3] != 0);
    freedPhyReg[0] = freeListPkg::phyReg_t'(fields[base + 4]);
    freedPhyReg[1] = freeListPkg::phyReg_t'(fields[base + 5]);
    stall          = (fields[base + 6] != 0);
    recoverFlag    = (fields[base + 7] != 0);
  endtask

  // columns 8..10 are the expected outputs before the next edge
  task automatic checkCase(input int n);
    int base;
    base = n * NumCols;
    checkPhyReg("freePhyReg_o[0]", freePhyReg[0], freeListPkg::phyReg_t'(fields[base + 8]));
    checkPhyReg("freePhyReg_o[1]", freePhyReg[1], freeListPkg::phyReg_t'(fields[base + 9]));
    checkFlag("freeListEmpty_o", freeListEmpty, fields[base + 10] != 0);
    checkFlag("flRamReady_o", flRamReady, 1'b1);
  endtask

  initial
  begin
    int limitNs;
    wait (casesLoaded === 1'b1);
    limitNs = (numCases * 3 + Depth + 20) * ClkPeriod;
    #(limitNs);
    abortRun("watchdog expired before all case lines were run");
  end

  initial
  begin
    int gap;
    void'($urandom(50));
    reset       = 1'b1;
    resetRams   = 1'b1;
    driveIdle();
    casesLoaded = 1'b0;
    loadCases();
    casesLoaded = 1'b1;
    repeat (4) @(posedge clk);
    @(negedge clk);
    checkFlag("flRamReady_o", flRamReady, 1'b0);
    reset     = 1'b0;
    resetRams = 1'b0;
    while (flRamReady !== 1'b1)
      @(negedge clk);
    for (int n = 0; n < numCases; n++)
    begin
      gap = $urandom % 3;
      repeat (gap)
      begin
        driveIdle();
        @(negedge clk);
      end
      driveCase(n);
      #1;
      checkCase(n);
      @(negedge clk);
    end
    driveIdle();
    $display("Test OK");
    $finish;
  end

endmodule

//--- src.f
logic/freeListPkg.sv
logic/freeListInit.sv
logic/freeListRam.sv
logic/commitPacker.sv
logic/headTracker.sv
logic/specFreeList.sv
sim/tbSpecFreeList.sv
